/* build.f */
irq_pkg.sv
core_ctrl_pkg.sv
irq_csr.sv
irq_group.sv
irq_arbiter.sv
sleep_unit.sv
int_subsystem.sv
int_subsystem_chk.sv
tb_int_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the interrupt subsystem testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f build.f \
  --top-module tb_int_subsystem --Mdir obj_dir -o tb_int_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_int_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
  exit 0
fi
exit 1

/* tb_int_subsystem.sv */
`timescale 1ns/100ps

module tb_int_subsystem import irq_pkg::*; import core_ctrl_pkg::*; ();

  localparam int GROUP_SIZE  = 8;
  localparam int N_RAND      = 400;
  // Reset, reset reads, CSR, pre-enable WFI, random, sleep sequence
  localparam int PLAN_CYCLES = 3 + 3 + 5 + 8 + N_RAND + 19;
  localparam int TIMEOUT     = PLAN_CYCLES * 3 / 2;

  logic      clk_i;
  logic      arst_n_i;
  irq_vec_t  irq_i;
  csr_wr_t   csr_wr_i;
  csr_addr_e csr_raddr_i;
  csr_data_t csr_rdata_o;
  logic      fetch_enable_i;
  logic      wfi_i;
  logic      irq_req_o;
  irq_id_t   irq_id_o;
  irq_vec_t  mip_o;
  logic      fetch_enable_o;
  logic      core_sleep_o;

  // Model state as the DUT stands after the last rising edge
  irq_vec_t     m_sync1;
  irq_vec_t     m_sync2;
  irq_vec_t     m_mie;
  logic         m_mie_en;
  logic         m_req;
  irq_id_t      m_id;
  logic         m_wu;
  sleep_state_e m_state;

  logic [31:0] rng_state = 32'd53410;
  int          cycle_cnt = 0;
  int          err_vec   = 0;
  int          err_id    = 0;
  int          err_data  = 0;
  int          err_bit   = 0;

  int_subsystem #(
    .GROUP_SIZE ( GROUP_SIZE )
  ) int_subsystem_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .irq_i          ( irq_i          ),
    .csr_wr_i       ( csr_wr_i       ),
    .csr_raddr_i    ( csr_raddr_i    ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .irq_req_o      ( irq_req_o      ),
    .irq_id_o       ( irq_id_o       ),
    .mip_o          ( mip_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .core_sleep_o   ( core_sleep_o   )
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Hard stop on runaway
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Random numbers and helpers
  ////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  function automatic csr_wr_t make_wr(input logic we, input csr_addr_e addr,
                                      input csr_data_t data);
    csr_wr_t w;
    w.we    = we;
    w.addr  = addr;
    w.wdata = data;
    return w;
  endfunction

  // Top line wins in a scan from the top down
  function automatic irq_id_t highest_line(input irq_vec_t v);
    irq_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int i = IRQ_NUM - 1; i >= 0; i--) begin
      if (v[i] && !found) begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  ////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////

  task automatic check_vec(input string name, input irq_vec_t act, input irq_vec_t exp);
    if (act !== exp) begin
      err_vec++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_id(input string name, input irq_id_t act, input irq_id_t exp);
    if (act !== exp) begin
      err_id++;
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_data(input string name, input csr_data_t act, input csr_data_t exp);
    if (act !== exp) begin
      err_data++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      err_bit++;
      $display("FAIL t=%0t %s got %b expected %b", $time, name, act, exp);
    end
  endtask

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  // One rising edge worth of model update
  task automatic model_advance(input irq_vec_t irq, input csr_wr_t wr, input logic fe,
                               input logic wfi);
    irq_vec_t     pend;
    logic         any;
    sleep_state_e st_n;
    pend = m_sync2 & m_mie;
    any  = |pend;
    st_n = m_state;
    case (m_state)
      ST_BOOT:  if (fe) st_n = ST_RUN;
      ST_RUN:   if (wfi && !m_wu) st_n = ST_SLEEP;
      ST_SLEEP: if (m_wu) st_n = ST_RUN;
      default:  st_n = ST_BOOT;
    endcase
    // Id only follows an actual request
    if (any && m_mie_en) m_id = highest_line(pend);
    m_req   = any && m_mie_en;
    m_wu    = any;
    m_state = st_n;
    m_sync2 = m_sync1;
    m_sync1 = irq;
    if (wr.we && wr.addr == CSR_MIE) m_mie = wr.wdata;
    if (wr.we && wr.addr == CSR_MSTATUS) m_mie_en = wr.wdata[MSTATUS_MIE_BIT];
  endtask

  task automatic check_outputs();
    csr_data_t exp_rd;
    exp_rd = '0;
    case (csr_raddr_i)
      CSR_MSTATUS: exp_rd[MSTATUS_MIE_BIT] = m_mie_en;
      CSR_MIE:     exp_rd = m_mie;
      CSR_MIP:     exp_rd = m_sync2;
      default:     exp_rd = '0;
    endcase
    check_vec("mip_o", mip_o, m_sync2);
    check_bit("irq_req_o", irq_req_o, m_req);
    check_id("irq_id_o", irq_id_o, m_id);
    check_data("csr_rdata_o", csr_rdata_o, exp_rd);
    check_bit("fetch_enable_o", fetch_enable_o, m_state != ST_BOOT);
    check_bit("core_sleep_o", core_sleep_o, m_state == ST_SLEEP);
  endtask

  // Drive on a falling edge and compare on the next one
  task automatic run_cycle(input irq_vec_t irq, input csr_wr_t wr, input csr_addr_e raddr,
                           input logic fe, input logic wfi);
    irq_i          = irq;
    csr_wr_i       = wr;
    csr_raddr_i    = raddr;
    fetch_enable_i = fe;
    wfi_i          = wfi;
    model_advance(irq, wr, fe, wfi);
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic idle(input irq_vec_t irq, input csr_addr_e raddr, input int n);
    repeat (n) run_cycle(irq, make_wr(1'b0, CSR_MSTATUS, '0), raddr, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    irq_i          = '0;
    csr_wr_i       = make_wr(1'b0, CSR_MSTATUS, '0);
    csr_raddr_i    = CSR_MSTATUS;
    fetch_enable_i = 1'b0;
    wfi_i          = 1'b0;
    arst_n_i       = 1'b0;
    m_sync1 = '0;
    m_sync2 = '0;
    m_mie   = '0;
    m_mie_en = 1'b0;
    m_req   = 1'b0;
    m_id    = '0;
    m_wu    = 1'b0;
    m_state = ST_BOOT;
    // Three rising edges in reset
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Everything reads zero after reset
    check_outputs();
    idle('0, CSR_MSTATUS, 1);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0);
    idle('0, CSR_MIE, 1);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0);
    idle('0, CSR_MIP, 1);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0);

    // Register readback
    draw(r1);
    draw(r2);
    run_cycle('0, make_wr(1'b1, CSR_MIE, r1), CSR_MIE, 1'b0, 1'b0);
    check_data("csr_rdata_o", csr_rdata_o, r1);
    run_cycle('0, make_wr(1'b1, CSR_MSTATUS, 32'hFFFF_FFFF), CSR_MSTATUS, 1'b0, 1'b0);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0000_0008);
    run_cycle('0, make_wr(1'b1, CSR_MIP, r2), CSR_MIP, 1'b0, 1'b0);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0);
    idle('0, CSR_MIE, 1);
    check_data("csr_rdata_o", csr_rdata_o, r1);
    run_cycle('0, make_wr(1'b1, CSR_MSTATUS, 32'hFFFF_FFF7), CSR_MSTATUS, 1'b0, 1'b0);
    check_data("csr_rdata_o", csr_rdata_o, 32'h0);

    // WFI before fetch enable is ignored
    repeat (4) begin
      run_cycle('0, make_wr(1'b0, CSR_MSTATUS, '0), CSR_MIP, 1'b0, 1'b1);
      check_bit("core_sleep_o", core_sleep_o, 1'b0);
      idle('0, CSR_MIP, 1);
      check_bit("fetch_enable_o", fetch_enable_o, 1'b0);
    end

    // Random lines, writes, WFI and fetch enable
    repeat (N_RAND) begin
      draw(r1);
      draw(r2);
      draw(r3);
      draw(r4);
      run_cycle(r1 & r2,
                make_wr(r3[0] & r3[1], csr_addr_e'(r3[5:4] % 2'd3), r4),
                csr_addr_e'(r3[9:8] % 2'd3),
                r3[15:12] == 4'h0,
                r3[18:16] == 3'h0);
    end

    // Wake up from whatever state random left behind
    run_cycle('1, make_wr(1'b1, CSR_MIE, '1), CSR_MIE, 1'b1, 1'b0);
    idle('1, CSR_MIE, 3);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    // One enabled line with the global enable off while the pipeline drains
    run_cycle('0, make_wr(1'b1, CSR_MIE, 32'h0000_0100), CSR_MIE, 1'b0, 1'b0);
    run_cycle('0, make_wr(1'b1, CSR_MSTATUS, '0), CSR_MSTATUS, 1'b0, 1'b0);
    idle('0, CSR_MIP, 2);
    run_cycle('0, make_wr(1'b0, CSR_MSTATUS, '0), CSR_MIP, 1'b0, 1'b1);
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    idle('0, CSR_MIP, 2);
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    // Line 8 wakes it after sync, arbiter and FSM edges
    idle(32'h0000_0100, CSR_MIP, 4);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    check_bit("irq_req_o", irq_req_o, 1'b0);
    // WFI with wake-up present keeps it running
    run_cycle(32'h0000_0100, make_wr(1'b0, CSR_MSTATUS, '0), CSR_MIP, 1'b0, 1'b1);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    idle('0, CSR_MIP, 3);

    $display("Errors: vec=%0d id=%0d data=%0d bit=%0d total=%0d",
             err_vec, err_id, err_data, err_bit, err_vec + err_id + err_data + err_bit);
    if (err_vec + err_id + err_data + err_bit == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* int_subsystem_chk.sv */
`timescale 1ns/100ps

module int_subsystem_chk (
  input logic clk_i,
  input logic arst_n_i,
  // Global enable from the CSR block
  input logic m_ie_i,
  input logic irq_req_i,
  input logic wfi_i,
  // Sticky fetch enable and sleep status
  input logic fetch_enabled_i,
  input logic core_sleep_i
);

  //////////////////////////////////////////////////
  // Request and sleep rules
  //////////////////////////////////////////////////

  // Request lags the enable by the arbiter register
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_req_i |-> $past(m_ie_i))
    else $error("irq_req_o high without global enable");

  // Sleep only after boot
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_sleep_i |-> fetch_enabled_i)
    else $error("core_sleep_o high without fetch enable");

  // Boot state ignores WFI
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!fetch_enabled_i && wfi_i) |=> !core_sleep_i)
    else $error("wfi_i acted before fetch enable");

  // Fetch enable never drops
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fetch_enabled_i |=> fetch_enabled_i)
    else $error("fetch_enable_o dropped");

endmodule

bind int_subsystem int_subsystem_chk int_subsystem_chk_i (
  .clk_i           ( clk_i          ),
  .arst_n_i        ( arst_n_i       ),
  .m_ie_i          ( m_ie           ),
  .irq_req_i       ( irq_req_o      ),
  .wfi_i           ( wfi_i          ),
  .fetch_enabled_i ( fetch_enable_o ),
  .core_sleep_i    ( core_sleep_o   )
);

/* int_subsystem.sv */
`timescale 1ns/100ps

module int_subsystem import irq_pkg::*; import core_ctrl_pkg::*; #(
  parameter int GROUP_SIZE = 8
) (
  input  logic      clk_i,
  input  logic      arst_n_i,

  // Level sensitive interrupt lines
  input  irq_vec_t  irq_i,

  // Register port
  input  csr_wr_t   csr_wr_i,
  input  csr_addr_e csr_raddr_i,
  output csr_data_t csr_rdata_o,

  // Core control
  input  logic      fetch_enable_i,
  input  logic      wfi_i,

  // Interrupt request to the core
  output logic      irq_req_o,
  output irq_id_t   irq_id_o,

  // Synchronized pending lines
  output irq_vec_t  mip_o,

  output logic      fetch_enable_o,
  output logic      core_sleep_o
);

  localparam int NUM_GROUPS = IRQ_NUM / GROUP_SIZE;

  // CSR to groups and arbiter
  irq_vec_t                       mie;
  logic                           m_ie;

  // Group results into the arbiter
  grp_result_t [NUM_GROUPS-1:0]   results;

  // Arbiter to sleep FSM
  logic                           irq_wu;

  //////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////

  // MIP readback taken straight from the output port
  irq_csr irq_csr_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .csr_wr_i    ( csr_wr_i    ),
    .csr_raddr_i ( csr_raddr_i ),
    .mip_i       ( mip_o       ),
    .mie_o       ( mie         ),
    .m_ie_o      ( m_ie        ),
    .csr_rdata_o ( csr_rdata_o )
  );

  //////////////////////////////////////////////////
  // Line groups
  //////////////////////////////////////////////////

  // Each group owns a contiguous slice of lines
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : gen_group
    irq_group #(
      .GROUP_SIZE ( GROUP_SIZE ),
      .GROUP_IDX  ( g          )
    ) irq_group_i (
      .clk_i    ( clk_i                              ),
      .arst_n_i ( arst_n_i                           ),
      .irq_i    ( irq_i[g*GROUP_SIZE +: GROUP_SIZE]  ),
      .mie_i    ( mie[g*GROUP_SIZE +: GROUP_SIZE]    ),
      .mip_o    ( mip_o[g*GROUP_SIZE +: GROUP_SIZE]  ),
      .result_o ( results[g]                         )
    );
  end

  //////////////////////////////////////////////////
  // Arbiter and sleep control
  //////////////////////////////////////////////////

  irq_arbiter #(
    .GROUP_SIZE ( GROUP_SIZE )
  ) irq_arbiter_i (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .results_i ( results   ),
    .m_ie_i    ( m_ie      ),
    .irq_req_o ( irq_req_o ),
    .irq_id_o  ( irq_id_o  ),
    .irq_wu_o  ( irq_wu    )
  );

  // Ungated clock with sleep reported only
  sleep_unit sleep_unit_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .irq_wu_i       ( irq_wu         ),
    .fetch_enable_o ( fetch_enable_o ),
    .core_sleep_o   ( core_sleep_o   )
  );

endmodule

/* sleep_unit.sv */
`timescale 1ns/100ps

module sleep_unit import core_ctrl_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,

  // Outside level where only the first assertion matters
  input  logic fetch_enable_i,
  // One cycle pulse
  input  logic wfi_i,
  // Registered wake-up from the arbiter
  input  logic irq_wu_i,

  output logic fetch_enable_o,
  output logic core_sleep_o
);

  sleep_state_e state_q;
  sleep_state_e state_d;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait for the first fetch enable
      ST_BOOT: begin
        if (fetch_enable_i) begin
          state_d = ST_RUN;
        end
      end
      // WFI sleeps unless a wake-up is already there
      ST_RUN: begin
        if (wfi_i && !irq_wu_i) begin
          state_d = ST_SLEEP;
        end
      end
      // Any enabled pending line wakes without the global enable
      ST_SLEEP: begin
        if (irq_wu_i) begin
          state_d = ST_RUN;
        end
      end
      default: state_d = ST_BOOT;
    endcase
  end

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_BOOT;
    end else begin
      state_q <= state_d;
    end
  end

  // Sticky since boot is never re-entered
  assign fetch_enable_o = (state_q != ST_BOOT);

  // Status only while the clock keeps running
  assign core_sleep_o   = (state_q == ST_SLEEP);

endmodule

/* irq_arbiter.sv */
`timescale 1ns/100ps

module irq_arbiter import irq_pkg::*; #(
  parameter int GROUP_SIZE = 8
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,

  // One result per group indexed by group number
  input  grp_result_t [IRQ_NUM/GROUP_SIZE-1:0]   results_i,
  // Global enable
  input  logic                                   m_ie_i,

  output logic                                   irq_req_o,
  output irq_id_t                                irq_id_o,
  output logic                                   irq_wu_o
);

  localparam int NUM_GROUPS = IRQ_NUM / GROUP_SIZE;

  // Winner of the group scan
  logic    any_valid;
  irq_id_t win_id;

  // Registered request side
  logic    req_q;
  irq_id_t id_q;
  logic    wu_q;

  //////////////////////////////////////////////////
  // Group pick
  //////////////////////////////////////////////////

  // Higher groups hold higher ids so the last valid group wins
  always_comb begin
    any_valid = 1'b0;
    win_id    = '0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (results_i[g].valid) begin
        any_valid = 1'b1;
        win_id    = results_i[g].id;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
      id_q  <= '0;
      wu_q  <= 1'b0;
    end else begin
      // Request needs the global enable
      req_q <= any_valid && m_ie_i;
      // Wake-up ignores it
      wu_q  <= any_valid;
      // Id only moves with a request and holds otherwise
      if (any_valid && m_ie_i) begin
        id_q <= win_id;
      end
    end
  end

  assign irq_req_o = req_q;
  assign irq_id_o  = id_q;
  assign irq_wu_o  = wu_q;

endmodule

/* irq_group.sv */
`timescale 1ns/100ps

module irq_group import irq_pkg::*; #(
  parameter int GROUP_SIZE = 8,
  parameter int GROUP_IDX  = 0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Raw asynchronous lines of this group
  input  logic [GROUP_SIZE-1:0] irq_i,
  // Matching MIE slice
  input  logic [GROUP_SIZE-1:0] mie_i,

  // Synchronized lines as a slice of MIP
  output logic [GROUP_SIZE-1:0] mip_o,
  output grp_result_t           result_o
);

  // First line index of this group
  localparam int BASE = GROUP_IDX * GROUP_SIZE;

  // Synchronizer stages
  logic [GROUP_SIZE-1:0] sync_q1;
  logic [GROUP_SIZE-1:0] sync_q2;

  // Pending and enabled
  logic [GROUP_SIZE-1:0] pend;

  //////////////////////////////////////////////////
  // Two flop synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= irq_i;
      sync_q2 <= sync_q1;
    end
  end

  // MIP shows the lines before masking
  assign mip_o = sync_q2;

  //////////////////////////////////////////////////
  // Mask and priority encode
  //////////////////////////////////////////////////

  assign pend = sync_q2 & mie_i;

  // Ascending scan lets the highest set line land last
  always_comb begin
    result_o = '0;
    for (int i = 0; i < GROUP_SIZE; i++) begin
      if (pend[i]) begin
        result_o.valid = 1'b1;
        // Local index plus group base gives the global id
        result_o.id    = irq_id_t'(BASE + i);
      end
    end
  end

endmodule

/* irq_csr.sv */
`timescale 1ns/100ps

module irq_csr import irq_pkg::*; import core_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,

  // Write strobe and readback select
  input  csr_wr_t   csr_wr_i,
  input  csr_addr_e csr_raddr_i,

  // Synchronized pending lines for readback only
  input  irq_vec_t  mip_i,

  output irq_vec_t  mie_o,
  output logic      m_ie_o,
  output csr_data_t csr_rdata_o
);

  // Per line enable
  irq_vec_t mie_q;
  // Global enable in MSTATUS.MIE
  logic     m_ie_q;

  // Decoded write strobes
  logic     mie_we;
  logic     mstatus_we;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // MIP has no write strobe since it is read-only
  assign mie_we     = csr_wr_i.we && (csr_wr_i.addr == CSR_MIE);
  assign mstatus_we = csr_wr_i.we && (csr_wr_i.addr == CSR_MSTATUS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q  <= '0;
      m_ie_q <= 1'b0;
    end else begin
      // Full word into MIE
      if (mie_we) begin
        mie_q <= csr_wr_i.wdata;
      end
      // Only the MIE bit of MSTATUS is kept
      if (mstatus_we) begin
        m_ie_q <= csr_wr_i.wdata[MSTATUS_MIE_BIT];
      end
    end
  end

  assign mie_o  = mie_q;
  assign m_ie_o = m_ie_q;

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Combinational readback
  always_comb begin
    csr_rdata_o = '0;
    case (csr_raddr_i)
      // Other MSTATUS bits read as zero
      CSR_MSTATUS: csr_rdata_o[MSTATUS_MIE_BIT] = m_ie_q;
      CSR_MIE:     csr_rdata_o = mie_q;
      CSR_MIP:     csr_rdata_o = mip_i;
      default:     csr_rdata_o = '0;
    endcase
  end

endmodule

/* core_ctrl_pkg.sv */
package core_ctrl_pkg;

  //////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////

  // Register select on the small CSR port
  typedef enum logic [1:0] {
    CSR_MSTATUS = 2'd0,
    CSR_MIE     = 2'd1,
    CSR_MIP     = 2'd2
  } csr_addr_e;

  // One register word
  typedef logic [31:0] csr_data_t;

  // Single write with the strobe in we
  typedef struct packed {
    logic      we;
    csr_addr_e addr;
    csr_data_t wdata;
  } csr_wr_t;

  // Global machine interrupt enable inside MSTATUS
  localparam int MSTATUS_MIE_BIT = 3;

  //////////////////////////////////////////////////
  // Sleep FSM
  //////////////////////////////////////////////////

  // Boot waits for fetch enable before run and sleep alternate
  typedef enum logic [1:0] {
    ST_BOOT  = 2'd0,
    ST_RUN   = 2'd1,
    ST_SLEEP = 2'd2
  } sleep_state_e;

endpackage

/* irq_pkg.sv */
package irq_pkg;

  //////////////////////////////////////////////////
  // Line count and id width
  //////////////////////////////////////////////////

  // Machine interrupt lines in CLINT style
  localparam int IRQ_NUM = 32;

  // Bits needed to name one line
  localparam int IRQ_ID_W = $clog2(IRQ_NUM);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One bit per line for raw lines, MIE and MIP
  typedef logic [IRQ_NUM-1:0] irq_vec_t;

  // Index of a single line
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // Result of one group of lines
  typedef struct packed {
    // Some enabled line in the group is pending
    logic    valid;
    // Full line index rather than the local one
    irq_id_t id;
  } grp_result_t;

endpackage
